// File: Bender.yml
package:
  name: lz_match_decide

sources:
  - files:
      - hw/lz_match_pkg.sv
      - hw/cand_capture.sv
      - hw/cand_lane.sv
      - hw/match_select.sv
      - hw/lz_match_decide.sv
  - target: test
    files:
      - test/lz_match_chk.sv
      - test/tb_lz_match_decide.sv

// File: files.f
hw/lz_match_pkg.sv
hw/cand_capture.sv
hw/cand_lane.sv
hw/match_select.sv
hw/lz_match_decide.sv
test/lz_match_chk.sv
test/tb_lz_match_decide.sv

// File: hw/cand_capture.sv
// ================================================
// Beat capture for the match-decision pipeline.
// Registers the candidates and derives the permitted
// phases and the tie-order select.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module cand_capture (
   input  wire  logic                      clk,
   input  wire  logic                      rst_n,
   input  wire  logic                      in_valid,
   input  wire  lz_match_pkg::cand_t       cand [lz_match_pkg::NUM_PHASES],
   input  wire  lz_match_pkg::match_state_e state,
   input  wire  lz_match_pkg::dmw_t        dmw,
   output logic                            cap_valid,
   output lz_match_pkg::cand_t             cap_cand [lz_match_pkg::NUM_PHASES],
   output lz_match_pkg::match_state_e      cap_state,
   output lz_match_pkg::phase_t            cap_pval,
   output logic                            cap_tie_alt
);

   import lz_match_pkg::*;

   phase_t not_trunc;
   phase_t pval_d;

   // ================================================
   // permitted phases
   // ================================================
   always_comb begin
      for (int i = 0; i < NUM_PHASES; i++) begin
         not_trunc[i] = ~cand[i].truncated;
      end

      case (state)
         ST_SCAN: begin
            // the delayed window also opens the two upper phases.
            pval_d = (dmw[5:2] | {dmw[1:0], 2'b00}) & not_trunc;
         end
         default: begin
            pval_d = dmw[5:2];
         end
      endcase
   end

   // ================================================
   // beat registers
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         cap_cand    <= cand;
         cap_state   <= state;
         cap_pval    <= pval_d;
         cap_tie_alt <= dmw[2] & dmw[1];   // selects the TWO-first order.
      end
   end

endmodule

`default_nettype wire

// File: hw/cand_lane.sv
// ================================================
// One phase lane of the match decision.
// Remaps the phase, applies the minimum-length and
// window rules and computes the run length.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module cand_lane #(
   parameter int unsigned PHASE_IDX = 0
) (
   input  wire  logic                       clk,
   input  wire  logic                       rst_n,
   input  wire  logic                       cap_valid,
   input  wire  lz_match_pkg::cand_t        cand,
   input  wire  lz_match_pkg::match_state_e state,
   input  wire  lz_match_pkg::phase_t       pval,
   input  wire  logic                       tie_alt,
   output lz_match_pkg::lane_result_t       res,
   output logic                             res_valid,
   output logic                             res_tie_alt
);

   import lz_match_pkg::*;

   phase_t       phase_init;
   phase_t       phase_map;
   phase_t       phase_ok;
   logic         len_ok;
   length_t      run_len;
   lane_result_t res_d;

   always_comb begin
      phase_init            = '0;
      phase_init[PHASE_IDX] = cand.match_here;

      // phase remap for the unmatched states.
      phase_map = phase_init;
      case (state)
         ST_U1: begin
            if (phase_init[PH_FOUR]) begin
               phase_map = phase_t'(1 << PH_THREE);
            end
         end
         ST_U2: begin
            if (phase_init[PH_FOUR] || phase_init[PH_THREE]) begin
               phase_map = phase_t'(1 << PH_TWO);
            end
         end
         ST_U3: begin
            if (|phase_init[PH_FOUR:PH_TWO]) begin
               phase_map = phase_t'(1 << PH_ONE);
            end
         end
         default: begin
            phase_map = phase_init;
         end
      endcase

      // ================================================
      // minimum length
      // ================================================
      len_ok = 1'b0;
      if (phase_map[PH_ONE]) begin
         len_ok = cand.run_therm[2];
      end else if (phase_map[PH_TWO]) begin
         len_ok = cand.run_therm[1];
      end else if (phase_map[PH_THREE]) begin
         len_ok = cand.run_therm[1] | cand.run_therm[0];
      end else if (phase_map[PH_FOUR]) begin
         len_ok = 1'b1;
      end

      phase_ok = (len_ok && (|(phase_map & pval))) ? phase_map : '0;

      // set thermometer bits plus the phase position.
      run_len = '0;
      for (int b = 0; b < RUN_W; b++) begin
         run_len = run_len + length_t'(cand.run_therm[b]);
      end
      for (int p = 0; p < NUM_PHASES; p++) begin
         if (phase_ok[p]) begin
            run_len = run_len + length_t'(p + 1);
         end
      end

      res_d = '0;
      if (|phase_ok) begin
         res_d.phase     = phase_ok;
         res_d.offset    = cand.offset;
         res_d.run_therm = cand.run_therm;
         res_d.length    = run_len;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= cap_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cap_valid) begin
         res         <= res_d;
         res_tie_alt <= tie_alt;   // keeps the tie order with its beat.
      end
   end

endmodule

`default_nettype wire

// File: hw/lz_match_decide.sv
// ================================================
// LZ77 match decision, top level.
// Capture stage, four phase lanes and the selector,
// three cycles from beat to tuple.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module lz_match_decide (
   input  wire  logic                       clk,
   input  wire  logic                       rst_n,
   input  wire  logic                       in_valid,
   input  wire  lz_match_pkg::cand_t        cand [lz_match_pkg::NUM_PHASES],
   input  wire  lz_match_pkg::match_state_e state,
   input  wire  lz_match_pkg::dmw_t         dmw,
   output logic                             out_valid,
   output lz_match_pkg::match_tuple_t       tuple,
   output logic                             valid_run,
   output lz_match_pkg::phase_t             long_run_f
);

   import lz_match_pkg::*;

   logic                  cap_valid;
   cand_t                 cap_cand [NUM_PHASES];
   match_state_e          cap_state;
   phase_t                cap_pval;
   logic                  cap_tie_alt;
   lane_result_t          lane_res [NUM_PHASES];
   logic [NUM_PHASES-1:0] lane_vld;
   logic [NUM_PHASES-1:0] lane_tie;

   cand_capture cand_capture_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .cand        (cand),
      .state       (state),
      .dmw         (dmw),
      .cap_valid   (cap_valid),
      .cap_cand    (cap_cand),
      .cap_state   (cap_state),
      .cap_pval    (cap_pval),
      .cap_tie_alt (cap_tie_alt)
   );

   for (genvar i = 0; i < NUM_PHASES; i++) begin : lane_gen
      cand_lane #(
         .PHASE_IDX (i)
      ) cand_lane_inst (
         .clk         (clk),
         .rst_n       (rst_n),
         .cap_valid   (cap_valid),
         .cand        (cap_cand[i]),
         .state       (cap_state),
         .pval        (cap_pval),
         .tie_alt     (cap_tie_alt),
         .res         (lane_res[i]),
         .res_valid   (lane_vld[i]),
         .res_tie_alt (lane_tie[i])
      );
   end

   // lane 0 supplies the strobe and tie order for the whole beat.
   match_select match_select_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .lane_valid (lane_vld[0]),
      .lane_res   (lane_res),
      .tie_alt    (lane_tie[0]),
      .out_valid  (out_valid),
      .tuple      (tuple),
      .valid_run  (valid_run),
      .long_run_f (long_run_f)
   );

endmodule

`default_nettype wire

// File: hw/lz_match_pkg.sv
// ================================================
// LZ77 match-decision shared definitions.
// Widths, phase indices, state encoding and the
// candidate, lane-result and tuple records.
// ================================================

`default_nettype none

package lz_match_pkg;

   // ================================================
   // widths
   // ================================================
   localparam int NUM_PHASES = 4;
   localparam int OFFSET_W   = 12;
   localparam int RUN_W      = 12;
   localparam int LEN_W      = 5;   // up to twelve run bits plus phase four.

   // bit positions inside a one-hot phase vector.
   localparam int PH_ONE   = 0;
   localparam int PH_TWO   = 1;
   localparam int PH_THREE = 2;
   localparam int PH_FOUR  = 3;

   typedef logic [OFFSET_W-1:0]   offset_t;
   typedef logic [RUN_W-1:0]      run_therm_t;   // bit 0 is the nearest byte.
   typedef logic [NUM_PHASES-1:0] phase_t;
   typedef logic [LEN_W-1:0]      length_t;
   typedef logic [5:0]            dmw_t;

   // match-state of the beat.
   typedef enum logic [2:0] {
      ST_U0,
      ST_U1,
      ST_U2,
      ST_U3,
      ST_SCAN
   } match_state_e;

   // ================================================
   // records
   // ================================================

   // one candidate as delivered for a byte phase.
   typedef struct packed {
      logic       match_here;
      logic       truncated;
      offset_t    offset;
      run_therm_t run_therm;
   } cand_t;

   // qualified lane output. All fields are zero for a dropped candidate.
   typedef struct packed {
      phase_t     phase;
      offset_t    offset;
      run_therm_t run_therm;
      length_t    length;
   } lane_result_t;

   // winning match of a beat.
   typedef struct packed {
      phase_t     phase;
      offset_t    offset;
      run_therm_t run_therm;
      length_t    length;
   } match_tuple_t;

endpackage

`default_nettype wire

// File: hw/match_select.sv
// ================================================
// Match selector. Runs the pairwise tournament
// over the four lanes and registers the winning
// tuple with its run flags.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module match_select (
   input  wire  logic                       clk,
   input  wire  logic                       rst_n,
   input  wire  logic                       lane_valid,
   input  wire  lz_match_pkg::lane_result_t lane_res [lz_match_pkg::NUM_PHASES],
   input  wire  logic                       tie_alt,
   output logic                             out_valid,
   output lz_match_pkg::match_tuple_t       tuple,
   output logic                             valid_run,
   output lz_match_pkg::phase_t             long_run_f
);

   import lz_match_pkg::*;

   lane_result_t win_43;
   lane_result_t win_21;
   lane_result_t win_final;
   match_tuple_t tuple_d;
   phase_t       any_phase;
   phase_t       long_d;

   // a lower position in the tie order comes earlier. An empty phase comes last.
   function automatic logic [2:0] prio_rank(input phase_t ph, input logic alt);
      logic [2:0] rank;
      rank = 3'd4;
      if (alt) begin
         if (ph[PH_TWO]) begin
            rank = 3'd0;
         end else if (ph[PH_ONE]) begin
            rank = 3'd1;
         end else if (ph[PH_FOUR]) begin
            rank = 3'd2;
         end else if (ph[PH_THREE]) begin
            rank = 3'd3;
         end
      end else begin
         if (ph[PH_FOUR]) begin
            rank = 3'd0;
         end else if (ph[PH_THREE]) begin
            rank = 3'd1;
         end else if (ph[PH_TWO]) begin
            rank = 3'd2;
         end else if (ph[PH_ONE]) begin
            rank = 3'd3;
         end
      end
      return rank;
   endfunction

   // true when the second operand beats the first one.
   function automatic logic second_wins(input lane_result_t a,
                                        input lane_result_t b,
                                        input logic alt);
      if (a.length != b.length) begin
         return b.length > a.length;
      end
      if (a.phase != b.phase) begin
         return prio_rank(b.phase, alt) < prio_rank(a.phase, alt);
      end
      return b.offset < a.offset;
   endfunction

   // ================================================
   // tournament
   // ================================================
   always_comb begin
      win_43 = second_wins(lane_res[PH_FOUR], lane_res[PH_THREE], tie_alt) ?
               lane_res[PH_THREE] : lane_res[PH_FOUR];
      win_21 = second_wins(lane_res[PH_TWO], lane_res[PH_ONE], tie_alt) ?
               lane_res[PH_ONE] : lane_res[PH_TWO];
      win_final = second_wins(win_43, win_21, tie_alt) ? win_21 : win_43;

      any_phase = '0;
      long_d    = '0;
      for (int i = 0; i < NUM_PHASES; i++) begin
         any_phase = any_phase | lane_res[i].phase;
         if (lane_res[i].run_therm[RUN_W-1]) begin
            long_d = long_d | lane_res[i].phase;   // dropped lanes carry no phase.
         end
      end

      tuple_d           = '0;
      tuple_d.phase     = win_final.phase;
      tuple_d.offset    = win_final.offset;
      tuple_d.run_therm = win_final.run_therm;
      tuple_d.length    = win_final.length;
   end

   // ================================================
   // output registers
   // ================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         tuple      <= '0;
         valid_run  <= 1'b0;
         long_run_f <= '0;
      end else begin
         out_valid <= lane_valid;
         if (lane_valid) begin
            valid_run  <= |any_phase;
            long_run_f <= long_d;
            tuple      <= (|any_phase) ? tuple_d : '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: test/lz_match_chk.sv
// ================================================
// Protocol checker for the match decision, bound
// to the top level. Latency and output shape.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module lz_match_chk (
   input wire logic                       clk,
   input wire logic                       rst_n,
   input wire logic                       in_valid,
   input wire logic                       out_valid,
   input wire lz_match_pkg::match_tuple_t tuple,
   input wire logic                       valid_run,
   input wire lz_match_pkg::phase_t       long_run_f
);

   import lz_match_pkg::*;

   int fail_count = 0;

   // every beat leaves exactly three cycles after it entered.
   assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##3 out_valid)
      else begin
         $error("out_valid missing three cycles after in_valid");
         fail_count++;
      end
   assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid, 3))
      else begin
         $error("out_valid without in_valid three cycles before");
         fail_count++;
      end

   assert property (@(posedge clk) disable iff (!rst_n) !valid_run |-> tuple == '0)
      else begin
         $error("tuple not zero while valid_run is low");
         fail_count++;
      end
   assert property (@(posedge clk) disable iff (!rst_n) valid_run |-> $onehot(tuple.phase))
      else begin
         $error("tuple phase not one-hot while valid_run is high");
         fail_count++;
      end

   assert property (@(posedge clk) !rst_n |->
                    !out_valid && !valid_run && long_run_f == '0 && tuple == '0)
      else begin
         $error("outputs not cleared during reset");
         fail_count++;
      end

endmodule

bind lz_match_decide lz_match_chk lz_match_chk_inst (
   .clk        (clk),
   .rst_n      (rst_n),
   .in_valid   (in_valid),
   .out_valid  (out_valid),
   .tuple      (tuple),
   .valid_run  (valid_run),
   .long_run_f (long_run_f)
);

`default_nettype wire

// File: test/tb_lz_match_decide.sv
// ================================================
// Testbench for the LZ77 match decision.
// Directed and random beats checked against a
// reference model of the decision rules.
// ================================================

`timescale 1ns/1ps
`default_nettype none

module tb_lz_match_decide;

   import lz_match_pkg::*;

   localparam int          CLK_PERIOD  = 8;
   localparam int          RAND_BEATS  = 200;
   localparam int          TOTAL_BEATS = 4 + 3 + 7 + 6 + RAND_BEATS;
   localparam int          NUM_TESTS   = 5;
   localparam int          DRAIN_MAX   = 8;
   localparam int          WD_CYCLES   = TOTAL_BEATS + NUM_TESTS * DRAIN_MAX + 20;
   localparam int unsigned RAND_SEED   = 32'h9025;

   typedef cand_t [NUM_PHASES-1:0] beat_t;

   typedef struct packed {
      match_tuple_t tuple;
      logic         valid_run;
      phase_t       long_run_f;
   } expect_t;

   logic         clk;
   logic         rst_n;
   logic         in_valid;
   cand_t        cand [NUM_PHASES];
   match_state_e state;
   dmw_t         dmw;
   logic         out_valid;
   match_tuple_t tuple;
   logic         valid_run;
   phase_t       long_run_f;

   expect_t      expect_q [$];
   int           error_count = 0;
   int           check_count = 0;
   int           err_base    = 0;
   int           check_base  = 0;

   lz_match_decide lz_match_decide_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .cand       (cand),
      .state      (state),
      .dmw        (dmw),
      .out_valid  (out_valid),
      .tuple      (tuple),
      .valid_run  (valid_run),
      .long_run_f (long_run_f)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ================================================
   // reference model
   // ================================================

   // rank of a phase position in the tie order. Position 0 is phase ONE.
   function automatic int tie_rank(input int pos, input logic alt);
      if (alt) begin
         return (pos <= 1) ? 1 - pos : 5 - pos;
      end
      return 3 - pos;
   endfunction

   function automatic expect_t ref_decide(input beat_t c, input match_state_e st,
                                          input dmw_t w);
      expect_t e;
      phase_t  allowed;
      logic    alt;
      logic    keep [NUM_PHASES];
      int      pos [NUM_PHASES];
      int      len [NUM_PHASES];
      int      best;
      logic    take;
      e    = '0;
      best = -1;
      alt  = w[2] & w[1];
      for (int p = 0; p < NUM_PHASES; p++) begin
         allowed[p] = w[p + 2];
         if (st == ST_SCAN) begin
            allowed[p] = (w[p + 2] | (p >= 2 && w[p - 2])) & ~c[p].truncated;
         end
      end
      for (int i = 0; i < NUM_PHASES; i++) begin
         pos[i]  = i;
         keep[i] = c[i].match_here;
         if (st == ST_U1 && i == 3) pos[i] = 2;
         if (st == ST_U2 && i >= 2) pos[i] = 1;
         if (st == ST_U3 && i >= 1) pos[i] = 0;
         case (pos[i])
            0: keep[i] = keep[i] & c[i].run_therm[2];
            1: keep[i] = keep[i] & c[i].run_therm[1];
            2: keep[i] = keep[i] & (c[i].run_therm[1] | c[i].run_therm[0]);
            default: keep[i] = keep[i];
         endcase
         keep[i] = keep[i] & allowed[pos[i]];
         len[i]  = $countones(c[i].run_therm) + pos[i] + 1;
      end
      // a full tie keeps the higher lane, so the scan runs downwards.
      for (int i = NUM_PHASES - 1; i >= 0; i--) begin
         if (keep[i]) begin
            e.long_run_f[pos[i]] = e.long_run_f[pos[i]] | c[i].run_therm[RUN_W-1];
            take = (best < 0);
            if (best >= 0) begin
               if (len[i] != len[best]) take = len[i] > len[best];
               else if (pos[i] != pos[best])
                  take = tie_rank(pos[i], alt) < tie_rank(pos[best], alt);
               else take = c[i].offset < c[best].offset;
            end
            if (take) best = i;
         end
      end
      if (best >= 0) begin
         e.valid_run         = 1'b1;
         e.tuple.phase       = phase_t'(1 << pos[best]);
         e.tuple.offset      = c[best].offset;
         e.tuple.run_therm   = c[best].run_therm;
         e.tuple.length      = length_t'(len[best]);
      end
      return e;
   endfunction

   // ================================================
   // stimulus helpers
   // ================================================
   task automatic send_beat(input beat_t b, input match_state_e st, input dmw_t w);
      for (int i = 0; i < NUM_PHASES; i++) begin
         cand[i] = b[i];
      end
      state    = st;
      dmw      = w;
      in_valid = 1'b1;
      expect_q.push_back(ref_decide(b, st, w));
      @(posedge clk);
      #1;
      in_valid = 1'b0;   // the next beat may raise it again in the same step.
   endtask

   task automatic finish_test(input string name);
      for (int n = 0; n < DRAIN_MAX && expect_q.size() != 0; n++) begin
         @(posedge clk);
         #1;
      end
      assert (expect_q.size() == 0) else begin
         $display("test %s: %0d beats never produced an output", name, expect_q.size());
         error_count++;
         expect_q.delete();
      end
      $display("test %s: %0d checks, %0d errors", name, check_count - check_base,
               error_count - err_base);
      check_base = check_count;
      err_base   = error_count;
   endtask

   // ================================================
   // tests
   // ================================================
   task automatic single_lane();
      beat_t b;
      for (int i = 0; i < NUM_PHASES; i++) begin
         b                = '0;
         b[i].match_here  = 1'b1;
         b[i].offset      = offset_t'(12'h100 + i);
         b[i].run_therm   = 12'h07F;
         send_beat(b, ST_U0, 6'h3F);
      end
      finish_test("single lane");
   endtask

   task automatic phase_remap();
      beat_t b;
      b                = '0;
      b[3].match_here  = 1'b1;
      b[3].offset      = 12'h2A5;
      b[3].run_therm   = 12'h00F;
      send_beat(b, ST_U1, 6'h3F);
      send_beat(b, ST_U2, 6'h3F);
      send_beat(b, ST_U3, 6'h3F);
      finish_test("phase remap");
   endtask

   task automatic window_mask();
      beat_t b;
      b = '0;
      b[0] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h011, run_therm: 12'h003};
      send_beat(b, ST_U0, 6'h3F);   // ONE without its third byte.
      b = '0;
      b[1] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h012, run_therm: 12'h001};
      send_beat(b, ST_U0, 6'h3F);
      b = '0;
      b[2] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h013, run_therm: 12'h000};
      send_beat(b, ST_U0, 6'h3F);
      b = '0;
      b[3] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h014, run_therm: 12'h0FF};
      send_beat(b, ST_U0, 6'h1F);
      b = '0;
      b[2] = '{match_here: 1'b1, truncated: 1'b1, offset: 12'h015, run_therm: 12'h0FF};
      send_beat(b, ST_SCAN, 6'h3F);
      b = '0;
      b[3] = '{match_here: 1'b1, truncated: 1'b1, offset: 12'h016, run_therm: 12'h0FF};
      send_beat(b, ST_SCAN, 6'h02);
      b[3].truncated = 1'b0;
      send_beat(b, ST_SCAN, 6'h02);   // the delayed window alone opens FOUR.
      finish_test("window mask");
   endtask

   task automatic tie_break();
      beat_t b;
      b = '0;
      b[0] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h040, run_therm: 12'h03F};
      b[1] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h030, run_therm: 12'h01F};
      b[2] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h020, run_therm: 12'h00F};
      b[3] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h010, run_therm: 12'h007};
      send_beat(b, ST_U0, 6'h3F);
      send_beat(b, ST_U0, 6'h3D);
      send_beat(b, ST_U0, 6'h3E);
      send_beat(b, ST_U0, 6'h37);
      b = '0;
      b[1] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h300, run_therm: 12'h01F};
      b[2] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h120, run_therm: 12'h01F};
      b[3] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h250, run_therm: 12'h01F};
      send_beat(b, ST_U3, 6'h3F);
      b = '0;
      b[2] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h080, run_therm: 12'h00F};
      b[3] = '{match_here: 1'b1, truncated: 1'b0, offset: 12'h040, run_therm: 12'h00F};
      send_beat(b, ST_U2, 6'h3F);
      finish_test("tie break");
   endtask

   task automatic random_stream();
      beat_t b;
      for (int n = 0; n < RAND_BEATS; n++) begin
         for (int i = 0; i < NUM_PHASES; i++) begin
            b[i].match_here = ($urandom_range(0, 3) != 0);
            b[i].truncated  = ($urandom_range(0, 3) == 0);
            b[i].offset     = offset_t'($urandom_range(0, 15));   // narrow range forces ties.
            if ($urandom_range(0, 1) == 1) begin
               b[i].run_therm = run_therm_t'(12'hFFF >> $urandom_range(0, 12));
            end else begin
               b[i].run_therm = run_therm_t'($urandom);
            end
         end
         send_beat(b, match_state_e'($urandom_range(0, 4)), dmw_t'($urandom));
      end
      finish_test("random stream");
   endtask

   // ================================================
   // comparison
   // ================================================
   always @(negedge clk) begin : compare_proc
      expect_t exp_r;
      if (rst_n && out_valid) begin
         assert (expect_q.size() != 0) else begin
            $display("out_valid rose at %0t while no beat was pending", $time);
            error_count++;
         end
         if (expect_q.size() != 0) begin
            exp_r       = expect_q.pop_front();
            check_count = check_count + 3;
            assert (tuple == exp_r.tuple) else begin
               $display("[ERROR] %0t tuple: expected %h, got %h", $time, exp_r.tuple, tuple);
               error_count++;
            end
            assert (valid_run == exp_r.valid_run) else begin
               $display("[ERROR] %0t valid_run: expected %b, got %b", $time,
                        exp_r.valid_run, valid_run);
               error_count++;
            end
            assert (long_run_f == exp_r.long_run_f) else begin
               $display("[ERROR] %0t long_run_f: expected %b, got %b", $time,
                        exp_r.long_run_f, long_run_f);
               error_count++;
            end
         end
      end
   end

   initial begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("Errors found");
      $finish;
   end

   initial begin
      rst_n    = 1'b1;
      in_valid = 1'b0;
      state    = ST_U0;
      dmw      = '0;
      for (int i = 0; i < NUM_PHASES; i++) begin
         cand[i] = '0;
      end
      void'($urandom(RAND_SEED));
      #1;
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      single_lane();
      phase_remap();
      window_mask();
      tie_break();
      random_stream();
      if (lz_match_decide_inst.lz_match_chk_inst.fail_count != 0) begin
         $display("bound checker flagged %0d assertion failures",
                  lz_match_decide_inst.lz_match_chk_inst.fail_count);
         error_count = error_count + lz_match_decide_inst.lz_match_chk_inst.fail_count;
      end
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
